/* files.f */
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_ctrl.sv
verilog/dcache_lru.sv
verilog/dcache_store.sv
verilog/dcache.sv
bench/mem_model.sv
bench/dcache_tb.sv

/* Makefile */
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP ?= dcache_tb
RTL_TOP ?= dcache
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale $(TIMESCALE) \
		--top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/dcache_tb.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_REQS = 200;
	localparam int SEED = 61201;
	// 200 requests x 4 accesses x 5 cycles, plus reset and flush, with margin
	localparam int MAX_CYCLES = 6000;

	logic CLK = 1'b0;
	logic nRST;
	logic halt;
	logic dmem_ren;
	logic dmem_wen;
	logic [`DC_WORD_W-1:0] dmem_addr;
	logic [`DC_WORD_W-1:0] dmem_store;
	logic dhit;
	logic [`DC_WORD_W-1:0] dmem_load;
	logic flushed;
	logic dwait;
	logic [`DC_WORD_W-1:0] dload;
	logic dren;
	logic dwen;
	logic [`DC_WORD_W-1:0] daddr;
	logic [`DC_WORD_W-1:0] dstore;

	// Expected memory image, kept up to date by committed processor writes
	logic [`DC_WORD_W-1:0] shadow [64];
	logic [`DC_WORD_W-1:0] expect_load;
	logic [`DC_WORD_W-1:0] expect_store;

	int cycles = 0;
	int errors = 0;
	int reqs_done = 0;
	int mem_writes = 0;

	always #50 CLK = ~CLK;

	dcache dcache_inst (
		.CLK(CLK), .nRST(nRST), .halt(halt), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
		.dmem_addr(dmem_addr), .dmem_store(dmem_store), .dhit(dhit),
		.dmem_load(dmem_load), .flushed(flushed), .dwait(dwait), .dload(dload),
		.dren(dren), .dwen(dwen), .daddr(daddr), .dstore(dstore)
	);

	mem_model mem_inst (
		.CLK(CLK), .nRST(nRST), .dren(dren), .dwen(dwen), .daddr(daddr),
		.dstore(dstore), .dwait(dwait), .dload(dload)
	);

	//////////////////////////////
	// Shadow memory
	//////////////////////////////

	// Copies the start-up image during reset, then tracks each hit write
	always @(posedge CLK) begin
		if (!nRST) begin
			for (int i = 0; i < 64; i++) begin
				shadow[i] <= mem_inst.mem[i];
			end
		end else if (dhit && dmem_wen) begin
			shadow[dmem_addr[7:2]] <= dmem_store;
		end
	end

	assign expect_load = shadow[dmem_addr[7:2]];
	assign expect_store = shadow[daddr[7:2]];

	//////////////////////////////
	// Checks
	//////////////////////////////

	// Reset cycles plus the first cycle after
	a_reset_quiet: assert property (@(posedge CLK)
		(cycles <= 16) |-> !(dhit || dren || dwen || flushed))
	else begin
		errors++;
		$display("Fail %0t: cache output active during reset", $time);
	end

	a_load_value: assert property (@(posedge CLK) disable iff (!nRST)
		(dhit && dmem_ren) |-> (dmem_load == expect_load))
	else begin
		errors++;
		$display("Fail %0t: load from %08h returned %08h, expected %08h", $time,
			$sampled(dmem_addr), $sampled(dmem_load), $sampled(expect_load));
	end

	// Writebacks carry the newest data and stay inside the modelled range
	a_store_value: assert property (@(posedge CLK) disable iff (!nRST)
		(dwen && !dwait) |-> ((dstore == expect_store) && (daddr[31:8] == '0)))
	else begin
		errors++;
		$display("Fail %0t: memory write to %08h carried %08h, expected %08h", $time,
			$sampled(daddr), $sampled(dstore), $sampled(expect_store));
	end

	a_hold_on_wait: assert property (@(posedge CLK) disable iff (!nRST)
		dwait |=> ($stable(dren) && $stable(dwen) && $stable(daddr) && $stable(dstore)))
	else begin
		errors++;
		$display("Fail %0t: memory request changed while dwait was high", $time);
	end

	a_quiet_flushed: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |-> !(dren || dwen))
	else begin
		errors++;
		$display("Fail %0t: memory access after flushed", $time);
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic report_counts();
		$display("Requests %0d, memory writes %0d, errors %0d", reqs_done, mem_writes,
			errors);
	endtask

	// dhit is combinational, so look at it on the falling edge
	task automatic wait_hit();
		@(negedge CLK);
		while (!dhit) begin
			@(negedge CLK);
		end
		@(posedge CLK);
		#10;
	endtask

	task automatic compare_memory();
		for (int i = 0; i < 64; i++) begin
			if (mem_inst.mem[i] !== shadow[i]) begin
				errors++;
				$display("Fail %0t: memory word %08h holds %08h, expected %08h", $time,
					i * 4, mem_inst.mem[i], shadow[i]);
			end
		end
	endtask

	// Cycle budget and write count
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (dwen && !dwait) begin
			mem_writes <= mem_writes + 1;
		end
		if (cycles >= MAX_CYCLES) begin
			$display("Run timed out after %0d cycles waiting for dhit or flushed", cycles);
			report_counts();
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial begin
		logic [1:0] tag;
		logic [2:0] idx;
		logic blk;
		void'($urandom(SEED));
		nRST = 1'b0;
		halt = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		repeat (16) @(posedge CLK);
		#10;
		nRST = 1'b1;

		// Three tags per set, so each set sees evictions
		for (int n = 0; n < NUM_REQS; n++) begin
			tag = 2'($urandom_range(2, 0));
			idx = 3'($urandom_range(7, 0));
			blk = 1'($urandom_range(1, 0));
			dmem_addr = {24'b0, tag, idx, blk, 2'b00};
			if ($urandom_range(1, 0) == 1) begin
				dmem_ren = 1'b0;
				dmem_wen = 1'b1;
				dmem_store = $urandom();
			end else begin
				dmem_ren = 1'b1;
				dmem_wen = 1'b0;
			end
			wait_hit();
			reqs_done++;
		end

		// Flush everything dirty back to memory
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		halt = 1'b1;
		@(negedge CLK);
		while (!flushed) begin
			@(negedge CLK);
		end
		// Some cycles in the flushed state for the bus check
		repeat (4) @(negedge CLK);
		compare_memory();

		report_counts();
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* bench/mem_model.sv */
`default_nettype none

`include "dcache_config.svh"

module mem_model (
	input wire logic CLK,
	input wire logic nRST,
	input wire logic dren,
	input wire logic dwen,
	input wire logic [`DC_WORD_W-1:0] daddr,
	input wire logic [`DC_WORD_W-1:0] dstore,
	output logic dwait,
	output logic [`DC_WORD_W-1:0] dload
);
	timeunit 1ns;
	timeprecision 100ps;

	// 64 words cover tags 0 to 2 in every set
	logic [`DC_WORD_W-1:0] mem [64];

	// Wait cycles left before the current access completes
	logic [1:0] stretch;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			// Start-up contents, a scramble of the full byte address
			for (int i = 0; i < 64; i++) begin
				mem[i] <= ((32'(i) << 2) * 32'h9E37_79B1) ^ 32'h5A5A_A5A5;
			end
			stretch <= 2'($urandom_range(3, 0));
		end else if (dren || dwen) begin
			if (stretch == 2'd0) begin
				// Access completes at this edge
				if (dwen) begin
					mem[daddr[7:2]] <= dstore;
				end
				// Fresh wait count for the next access
				stretch <= 2'($urandom_range(3, 0));
			end else begin
				stretch <= stretch - 2'd1;
			end
		end
	end

	assign dwait = (dren || dwen) && (stretch != 2'd0);
	// Read data valid on the completing cycle
	assign dload = mem[daddr[7:2]];

endmodule

`default_nettype wire

/* verilog/dcache.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache import dcache_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,
	// Processor side
	input wire logic halt,
	input wire logic dmem_ren,
	input wire logic dmem_wen,
	input wire logic [`DC_WORD_W-1:0] dmem_addr,
	input wire logic [`DC_WORD_W-1:0] dmem_store,
	output logic dhit,
	output logic [`DC_WORD_W-1:0] dmem_load,
	output logic flushed,
	// Memory side
	input wire logic dwait,
	input wire logic [`DC_WORD_W-1:0] dload,
	output logic dren,
	output logic dwen,
	output logic [`DC_WORD_W-1:0] daddr,
	output logic [`DC_WORD_W-1:0] dstore
);

	//////////////////////////////
	// Internal nets
	//////////////////////////////

	// Request address, decoded into fields downstream
	dcache_addr_t req_addr;

	// Controller to store
	logic fill_en;
	logic fill_second;
	logic hit_write;
	logic clean_en;
	logic scan_sel;
	logic victim_sel;
	logic word_sel;

	// Controller to LRU
	logic touch;

	// Store back to controller
	logic tag_hit;
	logic victim_dirty;
	logic some_dirty;

	// Between store and LRU
	logic victim_way;
	logic hit_way;

	assign req_addr.raw = dmem_addr;

	dcache_ctrl u_ctrl (
		.CLK(CLK), .nRST(nRST), .halt(halt), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
		.dwait(dwait), .tag_hit(tag_hit), .victim_dirty(victim_dirty),
		.some_dirty(some_dirty), .dhit(dhit), .dren(dren), .dwen(dwen), .flushed(flushed),
		.fill_en(fill_en), .fill_second(fill_second), .hit_write(hit_write),
		.clean_en(clean_en), .scan_sel(scan_sel), .victim_sel(victim_sel),
		.word_sel(word_sel), .touch(touch)
	);

	// Memory port of the cache is driven straight from the store
	dcache_store u_store (
		.CLK(CLK), .nRST(nRST), .addr(req_addr), .store_data(dmem_store),
		.fill_data(dload), .hit_write(hit_write), .fill_en(fill_en),
		.fill_second(fill_second), .clean_en(clean_en), .scan_sel(scan_sel),
		.victim_sel(victim_sel), .word_sel(word_sel), .victim_way(victim_way),
		.tag_hit(tag_hit), .hit_way(hit_way), .load_data(dmem_load),
		.victim_dirty(victim_dirty), .some_dirty(some_dirty), .mem_addr(daddr),
		.mem_data(dstore)
	);

	dcache_lru u_lru (
		.CLK(CLK), .nRST(nRST), .addr(req_addr), .touch(touch), .hit_way(hit_way),
		.victim_way(victim_way)
	);

endmodule

`default_nettype wire

/* verilog/dcache_store.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_store import dcache_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,
	input wire dcache_addr_t addr,
	input wire logic [`DC_WORD_W-1:0] store_data,
	input wire logic [`DC_WORD_W-1:0] fill_data,
	input wire logic hit_write,
	input wire logic fill_en,
	input wire logic fill_second,
	input wire logic clean_en,
	input wire logic scan_sel,
	input wire logic victim_sel,
	input wire logic word_sel,
	input wire logic victim_way,
	output logic tag_hit,
	output logic hit_way,
	output logic [`DC_WORD_W-1:0] load_data,
	output logic victim_dirty,
	output logic some_dirty,
	output logic [`DC_WORD_W-1:0] mem_addr,
	output logic [`DC_WORD_W-1:0] mem_data
);

	// Line status, indexed [way][set]
	logic [1:0][`DC_SETS-1:0] valid;
	logic [1:0][`DC_SETS-1:0] dirty;

	// Tag and data arrays, data is [way][set][word]
	logic [`DC_TAG_W-1:0] tags [2][`DC_SETS];
	logic [`DC_WORD_W-1:0] data [2][`DC_SETS][2];

	// Per-way match for the requested set
	logic [1:0] match;

	// Line picked by the dirty scan
	logic [`DC_IDX_W-1:0] scan_set;
	logic scan_way;

	//////////////////////////////
	// Hit lookup
	//////////////////////////////

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			match[w] = valid[w][addr.fields.idx] &&
				(tags[w][addr.fields.idx] == addr.fields.tag);
		end
	end

	assign tag_hit = |match;
	// Way 1 only when it matched, way 0 otherwise
	assign hit_way = match[1];

	// Only meaningful while dhit is high
	assign load_data = data[hit_way][addr.fields.idx][addr.fields.blkoff];

	// Victim needs a writeback before it can be refilled
	assign victim_dirty = dirty[victim_way][addr.fields.idx];

	//////////////////////////////
	// Dirty scan for the flush
	//////////////////////////////

	// Walk set-major, way-minor; the last dirty line found wins
	always_comb begin
		some_dirty = 1'b0;
		scan_set = '0;
		scan_way = 1'b0;
		for (int s = 0; s < `DC_SETS; s++) begin
			for (int w = 0; w < 2; w++) begin
				if (dirty[w][s]) begin
					some_dirty = 1'b1;
					scan_set = `DC_IDX_W'(s);
					scan_way = w[0];
				end
			end
		end
	end

	//////////////////////////////
	// Status bits
	//////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid <= '0;
			dirty <= '0;
		end else if (hit_write) begin
			// Line is already valid on a hit
			dirty[hit_way][addr.fields.idx] <= 1'b1;
		end else if (fill_en) begin
			// First word invalidates, second word revalidates clean
			valid[victim_way][addr.fields.idx] <= fill_second;
			if (fill_second) begin
				dirty[victim_way][addr.fields.idx] <= 1'b0;
			end
		end else if (clean_en) begin
			// Line just written back by the flush
			dirty[scan_way][scan_set] <= 1'b0;
		end
	end

	//////////////////////////////
	// Tag and data arrays
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (hit_write) begin
			data[hit_way][addr.fields.idx][addr.fields.blkoff] <= store_data;
		end else if (fill_en) begin
			data[victim_way][addr.fields.idx][fill_second] <= fill_data;
			// Tag goes in with the word that completes the line
			if (fill_second) begin
				tags[victim_way][addr.fields.idx] <= addr.fields.tag;
			end
		end
	end

	//////////////////////////////
	// Memory address and data
	//////////////////////////////

	always_comb begin
		mem_addr = `DC_POISON;
		mem_data = `DC_POISON;
		if (scan_sel) begin
			// Flush writeback of the scanned line
			if (some_dirty) begin
				mem_addr = {tags[scan_way][scan_set], scan_set, word_sel,
					{`DC_BYTE_W{1'b0}}};
				mem_data = data[scan_way][scan_set][word_sel];
			end
		end else if (victim_sel) begin
			// Eviction of the LRU way
			if (valid[victim_way][addr.fields.idx]) begin
				mem_addr = {tags[victim_way][addr.fields.idx], addr.fields.idx, word_sel,
					{`DC_BYTE_W{1'b0}}};
				mem_data = data[victim_way][addr.fields.idx][word_sel];
			end
		end else begin
			// Line fetch for the request, nothing to store
			mem_addr = {addr.fields.tag, addr.fields.idx, word_sel, {`DC_BYTE_W{1'b0}}};
		end
	end

	// A tag may live in only one way of a set
	generate
		for (genvar s = 0; s < `DC_SETS; s++) begin : g_tag_check
			a_single_copy: assert property (@(posedge CLK) disable iff (!nRST)
				!(valid[0][s] && valid[1][s] && (tags[0][s] == tags[1][s])));
		end
	endgenerate

endmodule

`default_nettype wire

/* verilog/dcache_lru.sv */
`default_nettype none

`include "dcache_config.svh"

module dcache_lru import dcache_pkg::*; (
	input wire logic CLK,
	input wire logic nRST,
	input wire dcache_addr_t addr,
	input wire logic touch,
	input wire logic hit_way,
	output logic victim_way
);

	// One bit per set naming the least recently used way
	// 0 means way 0 is next out, 1 means way 1
	logic [`DC_SETS-1:0] lru;

	//////////////////////////////
	// Update on hits
	//////////////////////////////

	// Only hits move the bit, a fill is followed by a hit anyway
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			lru <= '0;
		end else if (touch) begin
			// The other way becomes the replacement candidate
			lru[addr.fields.idx] <= ~hit_way;
		end
	end

	//////////////////////////////
	// Victim for the request
	//////////////////////////////

	// Stays put across a whole miss since fills leave lru alone
	assign victim_way = lru[addr.fields.idx];

endmodule

`default_nettype wire

/* verilog/dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl (
	input wire logic CLK,
	input wire logic nRST,
	input wire logic halt,
	input wire logic dmem_ren,
	input wire logic dmem_wen,
	input wire logic dwait,
	input wire logic tag_hit,
	input wire logic victim_dirty,
	input wire logic some_dirty,
	output logic dhit,
	output logic dren,
	output logic dwen,
	output logic flushed,
	output logic fill_en,
	output logic fill_second,
	output logic hit_write,
	output logic clean_en,
	output logic scan_sel,
	output logic victim_sel,
	output logic word_sel,
	output logic touch
);

	// State encoding
	localparam logic [3:0] IDLE    = 4'd0;
	localparam logic [3:0] WB1     = 4'd1;
	localparam logic [3:0] WB2     = 4'd2;
	localparam logic [3:0] FD1     = 4'd3;
	localparam logic [3:0] FD2     = 4'd4;
	localparam logic [3:0] DCHK    = 4'd5;
	localparam logic [3:0] WBD1    = 4'd6;
	localparam logic [3:0] WBD2    = 4'd7;
	localparam logic [3:0] FLUSHED = 4'd8;

	logic [3:0] state;
	logic [3:0] next_state;
	logic req;

	assign req = dmem_ren || dmem_wen;

	//////////////////////////////
	// Processor handshake
	//////////////////////////////

	// Hit answers in the request cycle, only from idle
	assign dhit = (state == IDLE) && req && tag_hit;
	assign hit_write = dhit && dmem_wen;
	// Reads and writes both refresh the LRU bit
	assign touch = dhit;

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Halt wins over a pending request
				if (halt) begin
					next_state = DCHK;
				end else if (req && !tag_hit) begin
					next_state = victim_dirty ? WB1 : FD1;
				end
			end
			// Each memory state advances on completion
			WB1: if (!dwait) next_state = WB2;
			WB2: if (!dwait) next_state = FD1;
			FD1: if (!dwait) next_state = FD2;
			// Line complete, the retried request hits next cycle
			FD2: if (!dwait) next_state = IDLE;
			DCHK: begin
				next_state = some_dirty ? WBD1 : FLUSHED;
			end
			WBD1: if (!dwait) next_state = WBD2;
			// Back to rescan with this line now clean
			WBD2: if (!dwait) next_state = DCHK;
			// Held until reset
			FLUSHED: next_state = FLUSHED;
			default: next_state = IDLE;
		endcase
	end

	//////////////////////////////
	// Outputs per state
	//////////////////////////////

	always_comb begin
		dren = 1'b0;
		dwen = 1'b0;
		flushed = 1'b0;
		fill_en = 1'b0;
		fill_second = 1'b0;
		clean_en = 1'b0;
		scan_sel = 1'b0;
		victim_sel = 1'b0;
		word_sel = 1'b0;
		case (state)
			WB1: begin
				dwen = 1'b1;
				victim_sel = 1'b1;
			end
			WB2: begin
				dwen = 1'b1;
				victim_sel = 1'b1;
				word_sel = 1'b1;
			end
			FD1: begin
				dren = 1'b1;
				// dload is captured only on the completing edge
				fill_en = !dwait;
			end
			FD2: begin
				dren = 1'b1;
				word_sel = 1'b1;
				fill_en = !dwait;
				fill_second = 1'b1;
			end
			WBD1: begin
				dwen = 1'b1;
				scan_sel = 1'b1;
			end
			WBD2: begin
				dwen = 1'b1;
				scan_sel = 1'b1;
				word_sel = 1'b1;
				clean_en = !dwait;
			end
			FLUSHED: flushed = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Memory sees one access type at a time
	a_one_access: assert property (@(posedge CLK) disable iff (!nRST)
		!(dren && dwen));

	// No way out of the flushed state short of reset
	a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		flushed |=> flushed);

endmodule

`default_nettype wire

/* verilog/dcache_pkg.sv */
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

	// One address word seen two ways
	// raw for the processor side, fields for the cache lookup
	typedef union packed {
		logic [`DC_WORD_W-1:0] raw;
		struct packed {
			logic [`DC_TAG_W-1:0] tag;
			logic [`DC_IDX_W-1:0] idx;
			// Selects word 0 or word 1 of the line
			logic blkoff;
			logic [`DC_BYTE_W-1:0] byteoff;
		} fields;
	} dcache_addr_t;

endpackage

`default_nettype wire

/* include/dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

//////////////////////////////
// Cache geometry
//////////////////////////////

// Width of a data word and of a byte address
`define DC_WORD_W 32

// Two ways per set, eight sets
`define DC_SETS 8
`define DC_IDX_W 3

// Address split
// tag | index | block offset | byte offset
`define DC_TAG_W 26
`define DC_BYTE_W 2

//////////////////////////////
// Error value
//////////////////////////////

// Driven on daddr and dstore when nothing valid is selected
`define DC_POISON 32'hBADC_0FFE

`endif
